//--- compile.f
source/lock_pkg.sv
source/lock_regs_pkg.sv
source/ms_tick_gen.sv
source/button_debounce.sv
source/code_matcher.sv
source/attempt_guard.sv
source/lock_config_regs.sv
source/door_fsm.sv
source/door_lock_top.sv
tests/tb_door_lock.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the door lock testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_door_lock -f compile.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_door_lock > sim.log 2>&1
cat sim.log

grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- source/attempt_guard.sv
`timescale 1ns/1ps
`default_nettype none

module attempt_guard
    import lock_pkg::*;
#(
    parameter int RETRY_MS     = 1000,
    parameter int BLOCK_MS     = 30000,
    parameter int MAX_ATTEMPTS = 5
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     ms_tick,
    input  logic     fail_pulse,
    input  logic     clear_attempts,
    output logic     lockout_done,
    output display_t digits
);

    localparam int PAUSE_MAX = (BLOCK_MS > RETRY_MS) ? BLOCK_MS : RETRY_MS;
    localparam int PW        = $clog2(PAUSE_MAX + 1);

    logic [2:0]    attempts;
    logic          pausing;
    logic [PW-1:0] pause_cnt;
    logic          blocked;
    logic [PW-1:0] pause_len;

    assign blocked   = (int'(attempts) > MAX_ATTEMPTS);
    assign pause_len = blocked ? PW'(BLOCK_MS) : PW'(RETRY_MS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            attempts     <= '0;
            pausing      <= 1'b0;
            pause_cnt    <= '0;
            lockout_done <= 1'b0;
        end else begin
            lockout_done <= 1'b0;
            if (fail_pulse) begin
                if (attempts != 3'd7)
                    attempts <= attempts + 1'b1;
                pausing   <= 1'b1;
                pause_cnt <= '0;
            end else if (clear_attempts) begin
                attempts <= '0;
            end else if (pausing && ms_tick) begin
                if (pause_cnt == pause_len - 1'b1) begin
                    pausing      <= 1'b0;
                    lockout_done <= 1'b1;
                    if (blocked)
                        attempts <= '0;   // Long pause served, start over
                end else begin
                    pause_cnt <= pause_cnt + 1'b1;
                end
            end
        end
    end

    // One mark per failed attempt, from digit 0 upward
    always_comb begin
        for (int k = 0; k < DISPLAY_DIGITS; k++)
            digits[k] = (k < int'(attempts)) ? DIGIT_FAIL : DIGIT_HASH;
    end

endmodule

`default_nettype wire

//--- source/button_debounce.sv
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
    parameter int DEBOUNCE_MS = 100
) (
    input  logic clk,
    input  logic rst,
    input  logic ms_tick,
    input  logic button,
    output logic press
);

    localparam int HW = $clog2(DEBOUNCE_MS + 1);

    logic          button_meta;
    logic          button_sync;
    logic [HW-1:0] held;   // Ticks the button has been down

    // Two-stage synchronizer for the raw button
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            button_meta <= 1'b0;
            button_sync <= 1'b0;
        end else begin
            button_meta <= button;
            button_sync <= button_meta;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held  <= '0;
            press <= 1'b0;
        end else if (button_sync) begin
            press <= 1'b0;
            if (ms_tick && held != HW'(DEBOUNCE_MS))
                held <= held + 1'b1;   // Saturates at the debounce time
        end else begin
            // Released, long enough presses count once
            press <= (held == HW'(DEBOUNCE_MS));
            held  <= '0;
        end
    end

endmodule

`default_nettype wire

//--- source/code_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module code_matcher
    import lock_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  code_t      entered,
    input  code_bank_t slot_codes,
    output logic       done,
    output logic       ok
);

    localparam int SW = $clog2(NUM_SLOTS);

    logic          busy;
    logic [SW-1:0] slot;
    logic          slot_hit;
    logic          last_slot;

    // An erased slot must never open the door
    assign slot_hit  = (slot_codes[slot] == entered) && (slot_codes[slot] != CODE_EMPTY);
    assign last_slot = (slot == SW'(NUM_SLOTS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            slot <= '0;
            done <= 1'b0;
            ok   <= 1'b0;
        end else begin
            done <= 1'b0;
            ok   <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                slot <= '0;   // Slot 1 first
            end else if (busy) begin
                if (slot_hit || last_slot) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    ok   <= slot_hit;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/door_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module door_fsm
    import lock_pkg::*;
    import lock_regs_pkg::*;
#(
    parameter int MS_PER_S = 1000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  ms_tick,
    input  logic  door_open,
    input  logic  unlatch_press,
    input  code_t code_in,
    input  logic  code_valid,
    input  logic  match_done,
    input  logic  match_ok,
    input  logic  lockout_done,
    input  logic  beep_en,
    input  secs_t beep_s,
    input  secs_t auto_lock_s,
    output logic  match_start,
    output code_t entered,
    output logic  fail_pulse,
    output logic  clear_attempts,
    output logic  lock_bolt,
    output logic  buzzer,
    output logic  keypad_en
);

    // Wide enough for the largest setting in ms ticks
    localparam int DW = $clog2((2 ** $bits(secs_t)) * MS_PER_S);

    door_state_t   state;
    door_state_t   state_nxt;
    logic [DW-1:0] dwell;             // Ticks spent in the current state
    logic [DW-1:0] auto_lock_ticks;
    logic [DW-1:0] beep_ticks;
    logic          key_strobe;
    logic          check_go;

    assign auto_lock_ticks = DW'(auto_lock_s) * DW'(MS_PER_S);
    assign beep_ticks      = DW'(beep_s) * DW'(MS_PER_S);
    assign key_strobe      = code_valid && keypad_en;   // Strobes are dropped otherwise
    assign check_go        = (state_nxt == CHECKING) && (state != CHECKING);

    always_comb begin
        state_nxt = state;
        case (state)
            INIT: begin
                if (!door_open)
                    state_nxt = LOCKED;
            end
            LOCKED, TIMEOUT_BEEP: begin
                state_nxt = LOCKED;   // Timeout beep lasts a single cycle
                if (unlatch_press) begin
                    state_nxt = UNLATCHED;
                end else if (key_strobe) begin
                    case (code_in[3:0])
                        DIGIT_TIMEOUT:           state_nxt = TIMEOUT_BEEP;
                        DIGIT_HASH, DIGIT_EMPTY: state_nxt = LOCKED;   // Cancelled entry
                        default:                 state_nxt = CHECKING;
                    endcase
                end
            end
            CHECKING: begin
                if (match_done)
                    state_nxt = match_ok ? UNLATCHED : LOCKOUT;
            end
            LOCKOUT: begin
                if (lockout_done)
                    state_nxt = LOCKED;
            end
            UNLATCHED: begin
                if (door_open)
                    state_nxt = OPEN;
                else if (unlatch_press || dwell >= auto_lock_ticks)
                    state_nxt = LOCKED;
            end
            OPEN: begin
                if (!door_open)
                    state_nxt = UNLATCHED;
                else if (beep_en && dwell >= beep_ticks)
                    state_nxt = OPEN_ALARM;
            end
            OPEN_ALARM: begin
                if (!door_open)
                    state_nxt = UNLATCHED;
            end
            default: state_nxt = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            dwell       <= '0;
            match_start <= 1'b0;
        end else begin
            state       <= state_nxt;
            match_start <= check_go;
            if (state_nxt != state)
                dwell <= '0;
            else if (ms_tick && dwell != '1)
                dwell <= dwell + 1'b1;
        end
    end

    // Entered code held for the matcher
    always_ff @(posedge clk) begin
        if (check_go)
            entered <= code_in;
    end

    assign fail_pulse     = (state == CHECKING) && match_done && !match_ok;
    assign clear_attempts = (state == CHECKING) && match_done && match_ok;

    assign lock_bolt = (state inside {LOCKED, CHECKING, LOCKOUT, TIMEOUT_BEEP});
    assign keypad_en = (state inside {LOCKED, TIMEOUT_BEEP});
    assign buzzer    = (state inside {OPEN_ALARM, TIMEOUT_BEEP});

endmodule

`default_nettype wire

//--- source/door_lock_top.sv
`timescale 1ns/1ps
`default_nettype none

module door_lock_top
    import lock_pkg::*;
    import lock_regs_pkg::*;
#(
    parameter int CLK_PER_MS   = 50000,
    parameter int MS_PER_S     = 1000,
    parameter int DEBOUNCE_MS  = 100,
    parameter int RETRY_MS     = 1000,
    parameter int BLOCK_MS     = 30000,
    parameter int MAX_ATTEMPTS = 5
) (
    input  logic      clk,
    input  logic      rst,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    input  logic      door_open,
    input  logic      inside_button,
    input  code_t     code_in,
    input  logic      code_valid,
    output logic      lock_bolt,
    output logic      buzzer,
    output logic      keypad_en,
    output display_t  digits
);

    logic       ms_tick;
    logic       unlatch_press;
    logic       match_start;
    logic       match_done;
    logic       match_ok;
    code_t      entered;
    logic       fail_pulse;
    logic       clear_attempts;
    logic       lockout_done;
    code_bank_t slot_codes;
    logic       beep_en;
    secs_t      beep_s;
    secs_t      auto_lock_s;

    ms_tick_gen #(.CLK_PER_MS(CLK_PER_MS)) u_tick (
        .clk(clk), .rst(rst), .ms_tick(ms_tick)
    );

    button_debounce #(.DEBOUNCE_MS(DEBOUNCE_MS)) u_button (
        .clk(clk), .rst(rst), .ms_tick(ms_tick),
        .button(inside_button), .press(unlatch_press)
    );

    lock_config_regs u_regs (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .slot_codes(slot_codes), .beep_en(beep_en), .beep_s(beep_s),
        .auto_lock_s(auto_lock_s)
    );

    code_matcher u_matcher (
        .clk(clk), .rst(rst), .start(match_start), .entered(entered),
        .slot_codes(slot_codes), .done(match_done), .ok(match_ok)
    );

    attempt_guard #(
        .RETRY_MS(RETRY_MS), .BLOCK_MS(BLOCK_MS), .MAX_ATTEMPTS(MAX_ATTEMPTS)
    ) u_guard (
        .clk(clk), .rst(rst), .ms_tick(ms_tick), .fail_pulse(fail_pulse),
        .clear_attempts(clear_attempts), .lockout_done(lockout_done), .digits(digits)
    );

    door_fsm #(.MS_PER_S(MS_PER_S)) u_fsm (
        .clk(clk), .rst(rst), .ms_tick(ms_tick),
        .door_open(door_open), .unlatch_press(unlatch_press),
        .code_in(code_in), .code_valid(code_valid),
        .match_done(match_done), .match_ok(match_ok), .lockout_done(lockout_done),
        .beep_en(beep_en), .beep_s(beep_s), .auto_lock_s(auto_lock_s),
        .match_start(match_start), .entered(entered),
        .fail_pulse(fail_pulse), .clear_attempts(clear_attempts),
        .lock_bolt(lock_bolt), .buzzer(buzzer), .keypad_en(keypad_en)
    );

endmodule

`default_nettype wire

//--- source/lock_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lock_config_regs
    import lock_pkg::*;
    import lock_regs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  apb_addr_t  paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    output code_bank_t slot_codes,
    output logic       beep_en,
    output secs_t      beep_s,
    output secs_t      auto_lock_s
);

    localparam int SW = $clog2(NUM_SLOTS);
    localparam int TW = $bits(secs_t);

    logic [5:0]    word_idx;
    logic [SW-1:0] slot_idx;
    logic [1:0]    word_part;   // 0 low, 1 mid, 2 high
    logic          is_ctrl;
    logic          is_code;
    logic          addr_ok;
    logic          wr_en;

    assign word_idx  = paddr[7:2];
    assign slot_idx  = SW'(word_idx / 6'd3);
    assign word_part = 2'(word_idx % 6'd3);
    assign is_ctrl   = (paddr == CTRL);
    assign is_code   = (paddr[1:0] == 2'b00) && (paddr < CTRL);
    assign addr_ok   = is_ctrl || is_code;
    assign wr_en     = psel && penable && pwrite && addr_ok;

    assign pready  = 1'b1;   // No wait states
    assign pslverr = psel && penable && !addr_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_codes  <= {NUM_SLOTS{CODE_EMPTY}};
            beep_en     <= RST_BEEP_EN;
            beep_s      <= RST_BEEP_S;
            auto_lock_s <= RST_AUTO_LOCK_S;
        end else if (wr_en) begin
            if (is_ctrl) begin
                beep_en     <= pwdata[CTRL_BEEP_EN_BIT];
                beep_s      <= pwdata[CTRL_BEEP_LSB +: TW];
                auto_lock_s <= pwdata[CTRL_AUTO_LSB +: TW];
            end else begin
                case (word_part)
                    2'd0:    slot_codes[slot_idx][31:0]  <= pwdata;
                    2'd1:    slot_codes[slot_idx][63:32] <= pwdata;
                    default: slot_codes[slot_idx][79:64] <= pwdata[15:0];
                endcase
            end
        end
    end

    // Readback, unmapped addresses read as zero
    always_comb begin
        prdata = '0;
        if (is_ctrl) begin
            prdata[CTRL_BEEP_EN_BIT]     = beep_en;
            prdata[CTRL_BEEP_LSB +: TW] = beep_s;
            prdata[CTRL_AUTO_LSB +: TW] = auto_lock_s;
        end else if (is_code) begin
            case (word_part)
                2'd0:    prdata = slot_codes[slot_idx][31:0];
                2'd1:    prdata = slot_codes[slot_idx][63:32];
                default: prdata = {16'h0, slot_codes[slot_idx][79:64]};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/lock_pkg.sv
`default_nettype none

package lock_pkg;

    localparam int CODE_DIGITS    = 20;
    localparam int DISPLAY_DIGITS = 6;
    localparam int NUM_SLOTS      = 4;   // Stored user codes

    typedef logic [3:0] digit_t;

    // Digit 0 is the first key pressed and sits in bits 3:0
    typedef logic [CODE_DIGITS*4-1:0] code_t;

    typedef logic [NUM_SLOTS-1:0][CODE_DIGITS*4-1:0] code_bank_t;

    typedef logic [DISPLAY_DIGITS-1:0][3:0] display_t;

    localparam digit_t DIGIT_EMPTY   = 4'hF;
    localparam digit_t DIGIT_HASH    = 4'hB;  // Cancel key, also blank display
    localparam digit_t DIGIT_TIMEOUT = 4'hE;
    localparam digit_t DIGIT_FAIL    = 4'hA;  // One failed attempt mark

    localparam code_t CODE_EMPTY = {CODE_DIGITS{DIGIT_EMPTY}};

    typedef enum logic [3:0] {
        INIT,
        LOCKED,        // Bolt out, keypad live
        CHECKING,      // Waiting on the matcher
        LOCKOUT,       // Retry or block pause
        UNLATCHED,     // Bolt in, door shut
        OPEN,
        OPEN_ALARM,    // Door held open too long
        TIMEOUT_BEEP
    } door_state_t;

endpackage

`default_nettype wire

//--- source/lock_regs_pkg.sv
`default_nettype none

package lock_regs_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [7:0]  secs_t;

    // Each code takes three words: bits 31:0, 63:32 and 79:64
    typedef enum logic [7:0] {
        CODE1_LO = 8'h00, CODE1_MID = 8'h04, CODE1_HI = 8'h08,
        CODE2_LO = 8'h0C, CODE2_MID = 8'h10, CODE2_HI = 8'h14,
        CODE3_LO = 8'h18, CODE3_MID = 8'h1C, CODE3_HI = 8'h20,
        CODE4_LO = 8'h24, CODE4_MID = 8'h28, CODE4_HI = 8'h2C,
        CTRL     = 8'h30
    } reg_addr_t;

    // CTRL fields
    localparam int CTRL_BEEP_EN_BIT = 0;
    localparam int CTRL_BEEP_LSB    = 4;
    localparam int CTRL_AUTO_LSB    = 12;

    localparam logic  RST_BEEP_EN     = 1'b1;
    localparam secs_t RST_BEEP_S      = 8'd5;
    localparam secs_t RST_AUTO_LOCK_S = 8'd5;

endpackage

`default_nettype wire

//--- source/ms_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ms_tick_gen #(
    parameter int CLK_PER_MS = 50000
) (
    input  logic clk,
    input  logic rst,
    output logic ms_tick
);

    localparam int CW = (CLK_PER_MS > 1) ? $clog2(CLK_PER_MS) : 1;

    logic [CW-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count   <= '0;
            ms_tick <= 1'b0;
        end else if (count == CW'(CLK_PER_MS - 1)) begin
            count   <= '0;   // Wrap, one pulse per millisecond
            ms_tick <= 1'b1;
        end else begin
            count   <= count + 1'b1;
            ms_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_door_lock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_door_lock
    import lock_pkg::*;
    import lock_regs_pkg::*;
();

    localparam int    CLK_PER_MS   = 4;
    localparam int    MS_PER_S     = 5;
    localparam int    DEBOUNCE_MS  = 3;
    localparam int    RETRY_MS     = 6;
    localparam int    BLOCK_MS     = 20;
    localparam int    MAX_ATTEMPTS = 5;
    localparam secs_t BEEP_S       = 8'd2;
    localparam secs_t AUTO_S       = 8'd3;

    logic      clk;
    logic      rst;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      door_open;
    logic      inside_button;
    code_t     code_in;
    logic      code_valid;
    logic      lock_bolt;
    logic      buzzer;
    logic      keypad_en;
    display_t  digits;

    integer      seed;
    code_t       stored [NUM_SLOTS];   // Model of the programmed codes
    logic        model_locked;
    logic        model_alarm;
    int          model_fails;
    logic        check_en;             // Checker compares only while set
    logic [25:0] expected_out;
    int          checks;
    int          value_errors;
    int          other_errors;

    door_lock_top #(
        .CLK_PER_MS(CLK_PER_MS), .MS_PER_S(MS_PER_S), .DEBOUNCE_MS(DEBOUNCE_MS),
        .RETRY_MS(RETRY_MS), .BLOCK_MS(BLOCK_MS), .MAX_ATTEMPTS(MAX_ATTEMPTS)
    ) DUT (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .door_open(door_open), .inside_button(inside_button),
        .code_in(code_in), .code_valid(code_valid),
        .lock_bolt(lock_bolt), .buzzer(buzzer), .keypad_en(keypad_en), .digits(digits)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic logic_check(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic display_check(input string name, input display_t exp, input display_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic data_check(input string name, input apb_data_t exp, input apb_data_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic window_check(input string name, input int lo, input int hi, input int act);
        checks++;
        if (act < lo || act > hi) begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %0d to %0d, got %0d", $time, name, lo, hi, act);
        end
    endtask

    task automatic report_timeout(input string what);
        other_errors++;
        $display("Timeout at %0t ns: %s", $time, what);
    endtask

    // Digit k carries a fail mark for each of the first fails digits
    function automatic display_t fail_marks(input int fails);
        display_t d;
        for (int k = 0; k < DISPLAY_DIGITS; k++)
            d[k] = (k < fails) ? DIGIT_FAIL : DIGIT_HASH;
        return d;
    endfunction

    // Expected {lock_bolt, buzzer, digits} for a settled door
    function automatic logic [25:0] predict_outputs(input logic locked, input logic alarm,
                                                    input int fails);
        return {locked, alarm, fail_marks(fails)};
    endfunction

    function automatic logic is_stored_code(input code_t c);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++)
            if (stored[s] == c && stored[s] != CODE_EMPTY)
                hit = 1'b1;   // Erased slots never open
        return hit;
    endfunction

    function automatic code_t random_code();
        code_t c;
        int    r;
        for (int i = 0; i < CODE_DIGITS; i++) begin
            r = $random(seed);
            c[4*i +: 4] = digit_t'((r & 32'h7fff_ffff) % 10);
        end
        return c;
    endfunction

    function automatic apb_data_t code_word(input code_t c, input int w);
        case (w)
            0:       return c[31:0];
            1:       return c[63:32];
            default: return {16'h0, c[79:64]};
        endcase
    endfunction

    // CTRL layout: bit 0 beep enable, 11:4 beep time, 19:12 auto-lock time
    function automatic apb_data_t ctrl_word(input logic en, input secs_t beep, input secs_t auto_s);
        apb_data_t w;
        w        = '0;
        w[0]     = en;
        w[11:4]  = beep;
        w[19:12] = auto_s;
        return w;
    endfunction

    function automatic logic output_value(input string name);
        case (name)
            "lock_bolt": return lock_bolt;
            "buzzer":    return buzzer;
            "keypad_en": return keypad_en;
            default:     return 1'bx;
        endcase
    endfunction

    always @(negedge clk) begin
        if (check_en) begin
            expected_out = predict_outputs(model_locked, model_alarm, model_fails);
            logic_check("lock_bolt", expected_out[25], lock_bolt);
            logic_check("buzzer", expected_out[24], buzzer);
            display_check("digits", expected_out[23:0], digits);
        end
    end

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(posedge clk);
        #10;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #10 penable = 1'b1;   // Access phase
        @(negedge clk);
        logic_check("pready", 1'b1, pready);
        err = pslverr;
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        #10;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #10 penable = 1'b1;
        @(negedge clk);
        logic_check("pready", 1'b1, pready);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic enter_code(input code_t c);
        @(posedge clk);
        #10;
        code_in    = c;
        code_valid = 1'b1;
        @(posedge clk);
        #10 code_valid = 1'b0;   // One-cycle strobe
    endtask

    task automatic wait_output(input string name, input logic val, input int limit,
                               output int n);
        @(negedge clk);
        n = 1;
        while (output_value(name) !== val && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (output_value(name) !== val)
            report_timeout($sformatf("%s did not reach %b within %0d cycles", name, val, limit));
    endtask

    task automatic hold_check(input int cycles);
        @(posedge clk);
        #10 check_en = 1'b1;
        repeat (cycles) @(posedge clk);
        #10 check_en = 1'b0;
    endtask

    task automatic press_button(input int cycles);
        @(posedge clk);
        #10 inside_button = 1'b1;
        repeat (cycles) @(posedge clk);
        #10 inside_button = 1'b0;
    endtask

    task automatic configure_over_apb();
        apb_data_t rd;
        logic      err;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            stored[s] = random_code();
            for (int w = 0; w < 3; w++)
                apb_write(apb_addr_t'(12*s + 4*w), code_word(stored[s], w), err);
        end
        apb_write(CTRL, ctrl_word(1'b1, BEEP_S, AUTO_S), err);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            for (int w = 0; w < 3; w++) begin
                apb_read(apb_addr_t'(12*s + 4*w), rd, err);
                data_check($sformatf("slot %0d word %0d", s + 1, w), code_word(stored[s], w), rd);
                logic_check("pslverr", 1'b0, err);
            end
        end
        apb_read(CTRL, rd, err);
        data_check("ctrl", ctrl_word(1'b1, BEEP_S, AUTO_S), rd);
        // Unmapped and misaligned addresses
        apb_read(8'h34, rd, err);
        data_check("unmapped read", '0, rd);
        logic_check("pslverr", 1'b1, err);
        apb_read(8'h02, rd, err);
        data_check("misaligned read", '0, rd);
        logic_check("pslverr", 1'b1, err);
        apb_write(8'h40, 32'hffff_ffff, err);
        logic_check("pslverr", 1'b1, err);
        apb_read(CTRL, rd, err);
        data_check("ctrl after bad write", ctrl_word(1'b1, BEEP_S, AUTO_S), rd);
    endtask

    task automatic unlatch_with_code(input int slot);
        int n;
        enter_code(stored[slot]);
        if (is_stored_code(stored[slot])) begin
            wait_output("lock_bolt", 1'b0, 7, n);   // 3 to 7 cycles after the strobe
            model_locked = 1'b0;
            model_fails  = 0;
        end
    endtask

    task automatic measure_auto_lock();
        int n;
        int exp_cycles;
        exp_cycles = int'(AUTO_S) * MS_PER_S * CLK_PER_MS;
        wait_output("lock_bolt", 1'b1, 4*exp_cycles, n);
        window_check("auto-lock cycles", exp_cycles - 4, exp_cycles + 4, n);
        model_locked = 1'b1;
        hold_check(4);
    endtask

    task automatic timeout_and_hash_codes();
        code_t c;
        int    beeps;
        c      = random_code();
        c[3:0] = DIGIT_TIMEOUT;
        enter_code(c);
        beeps = 0;
        repeat (6) begin
            @(negedge clk);
            if (buzzer === 1'b1)
                beeps++;
            logic_check("lock_bolt", 1'b1, lock_bolt);
        end
        window_check("timeout beep cycles", 1, 1, beeps);
        c      = stored[0];
        c[3:0] = DIGIT_HASH;   // Cancelled entry is ignored
        enter_code(c);
        repeat (8) begin
            @(negedge clk);
            logic_check("lock_bolt", 1'b1, lock_bolt);
            logic_check("keypad_en", 1'b1, keypad_en);
        end
    endtask

    task automatic open_door_beep();
        int   n;
        int   exp_cycles;
        logic err;
        exp_cycles = int'(BEEP_S) * MS_PER_S * CLK_PER_MS;
        unlatch_with_code(NUM_SLOTS - 1);
        @(posedge clk);
        #10 door_open = 1'b1;
        wait_output("buzzer", 1'b1, 4*exp_cycles, n);
        window_check("beep delay cycles", exp_cycles - 4, exp_cycles + 4, n);
        logic_check("lock_bolt", 1'b0, lock_bolt);
        model_alarm = 1'b1;
        hold_check(4);   // Alarm holds while the door stays open
        @(posedge clk);
        #10 door_open = 1'b0;
        wait_output("buzzer", 1'b0, 2, n);
        model_alarm = 1'b0;
        // Same door cycle with the beep switched off
        apb_write(CTRL, ctrl_word(1'b0, BEEP_S, AUTO_S), err);
        @(posedge clk);
        #10 door_open = 1'b1;
        repeat (2*exp_cycles) begin
            @(negedge clk);
            logic_check("buzzer", 1'b0, buzzer);
        end
        @(posedge clk);
        #10 door_open = 1'b0;
        wait_output("lock_bolt", 1'b1, 200, n);
        model_locked = 1'b1;
        apb_write(CTRL, ctrl_word(1'b1, BEEP_S, AUTO_S), err);
        hold_check(4);
    endtask

    task automatic inside_button_presses();
        int n;
        press_button(DEBOUNCE_MS * CLK_PER_MS / 3);   // Too short to count
        hold_check(20);
        press_button(5 * CLK_PER_MS);
        wait_output("lock_bolt", 1'b0, 10, n);
        model_locked = 1'b0;
        press_button(5 * CLK_PER_MS);
        wait_output("lock_bolt", 1'b1, 10, n);
        model_locked = 1'b1;
        hold_check(4);
    endtask

    task automatic wrong_code_lockout();
        code_t c;
        int    n;
        int    tries;
        int    pause;
        for (int i = 1; i <= MAX_ATTEMPTS + 1; i++) begin
            c     = random_code();
            tries = 0;
            while (is_stored_code(c) && tries < 8) begin
                c = random_code();
                tries++;
            end
            enter_code(c);
            model_fails = i;
            @(negedge clk);
            n = 1;
            while (digits !== fail_marks(model_fails) && n < 7) begin
                @(negedge clk);
                n++;
            end
            display_check("digits", fail_marks(model_fails), digits);
            logic_check("keypad_en", 1'b0, keypad_en);
            pause = (i > MAX_ATTEMPTS) ? BLOCK_MS : RETRY_MS;
            #10 check_en = 1'b1;
            repeat (pause * CLK_PER_MS - 8) begin
                @(negedge clk);
                logic_check("keypad_en", 1'b0, keypad_en);
            end
            #10 check_en = 1'b0;
            wait_output("keypad_en", 1'b1, 40, n);
            if (i > MAX_ATTEMPTS)
                model_fails = 0;   // Block pause clears the marks
            display_check("digits", fail_marks(model_fails), digits);
        end
        hold_check(4);
    endtask

    initial begin
        seed          = 32'h3214;
        rst           = 1'b1;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        door_open     = 1'b0;
        inside_button = 1'b0;
        code_in       = '0;
        code_valid    = 1'b0;
        check_en      = 1'b0;
        model_locked  = 1'b1;
        model_alarm   = 1'b0;
        model_fails   = 0;
        checks        = 0;
        value_errors  = 0;
        other_errors  = 0;
        for (int s = 0; s < NUM_SLOTS; s++)
            stored[s] = CODE_EMPTY;

        @(posedge clk);
        @(negedge clk);
        expected_out = predict_outputs(1'b0, 1'b0, 0);   // Everything inactive in reset
        logic_check("lock_bolt", expected_out[25], lock_bolt);
        logic_check("buzzer", expected_out[24], buzzer);
        logic_check("keypad_en", 1'b0, keypad_en);
        display_check("digits", expected_out[23:0], digits);
        @(posedge clk);
        #10 rst = 1'b0;
        begin : leave_init
            int n;
            wait_output("keypad_en", 1'b1, 5, n);
        end
        hold_check(4);

        configure_over_apb();
        unlatch_with_code(0);
        measure_auto_lock();
        timeout_and_hash_codes();
        open_door_beep();
        inside_button_presses();
        wrong_code_lockout();

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
